// File: source/key_extract_pkg.sv
// key extractor shared definitions
// PHV layout, key and table widths, FSM states and comparator encodings

package key_extract_pkg;

    // container geometry
    localparam int num_cont   = 8;
    localparam int cont_6b_w  = 48;
    localparam int cont_4b_w  = 32;
    localparam int cont_2b_w  = 16;
    localparam int cont_idx_w = 3;

    // comparator words and trailing metadata
    localparam int num_cmp    = 5;
    localparam int cmp_word_w = 20;
    localparam int meta_w     = 256;

    localparam int phv_len = num_cont * (cont_6b_w + cont_4b_w + cont_2b_w)
                           + num_cmp * cmp_word_w + meta_w;

    // two containers of each size plus one bit per comparator
    localparam int key_len = 2 * (cont_6b_w + cont_4b_w + cont_2b_w) + num_cmp;

    // six container indices, 6B pair first
    localparam int key_off_len = 6 * cont_idx_w;

    // containers packed from the PHV top, index 7 highest
    localparam int cont_6b_msb = phv_len - 1;
    localparam int cont_4b_msb = cont_6b_msb - num_cont * cont_6b_w;
    localparam int cont_2b_msb = cont_4b_msb - num_cont * cont_4b_w;

    // msb of comparator word 0, later words sit lower
    localparam int cmp_base = cont_2b_msb - num_cont * cont_2b_w;

    // tenant tag inside the metadata
    localparam int tenant_lsb = 133;
    localparam int tenant_w   = 4;

    typedef enum logic [2:0] {
        idle          = 3'd0,
        wait_operands = 3'd1,
        wait_table    = 3'd2,
        emit          = 3'd3,
        halt          = 3'd4
    } state_e;

    typedef enum logic [1:0] {
        op_gt   = 2'b00,
        op_ge   = 2'b01,
        op_eq   = 2'b10,
        op_true = 2'b11
    } cmp_op_e;

    typedef enum logic [1:0] {
        type_2b   = 2'b00,
        type_4b   = 2'b01,
        type_6b   = 2'b10,
        type_none = 2'b11
    } cont_type_e;

    typedef enum logic {
        sel_offset = 1'b0,
        sel_mask   = 1'b1
    } table_sel_e;

endpackage

// File: source/lookup_ram.sv
// per-tenant lookup table
// one write port, one read port with a registered output

`timescale 1ns/1ns

module lookup_ram #(
    parameter int DATA_W      = 18,
    parameter int TABLE_DEPTH = 16
) (
    input  logic                           clk,
    input  logic                           wr_en,
    input  logic [$clog2(TABLE_DEPTH)-1:0] wr_addr,
    input  logic [DATA_W-1:0]              wr_data,
    input  logic [$clog2(TABLE_DEPTH)-1:0] rd_addr,
    output logic [DATA_W-1:0]              rd_data
);

    logic [DATA_W-1:0] mem [TABLE_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // read sees writes from earlier edges only
        rd_data <= mem[rd_addr];
    end

    a_wr_addr_known: assert property (@(posedge clk) wr_en |-> !$isunknown(wr_addr))
        else $error("table write with unknown address");

endmodule

// File: source/key_operand_compare.sv
// stage comparator
// picks two 8-bit operands from the comparator word, registers them
// and evaluates the predicate bit for the key

`timescale 1ns/1ns

module key_operand_compare (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [key_extract_pkg::cmp_word_w-1:0]   cmp_word,
    input  logic [key_extract_pkg::num_cont-1:0][key_extract_pkg::cont_6b_w-1:0] cont_6b,
    input  logic [key_extract_pkg::num_cont-1:0][key_extract_pkg::cont_4b_w-1:0] cont_4b,
    input  logic [key_extract_pkg::num_cont-1:0][key_extract_pkg::cont_2b_w-1:0] cont_2b,
    output logic                                     cmp_bit
);

    key_extract_pkg::cmp_op_e opcode;
    logic [7:0]               op1_q;
    logic [7:0]               op2_q;

    // immediate or low byte of a container, none reads as zero
    function automatic logic [7:0] pick_operand(
        input logic                                  use_imm,
        input logic [7:0]                            imm,
        input key_extract_pkg::cont_type_e           ctype,
        input logic [key_extract_pkg::cont_idx_w-1:0] idx
    );
        logic [7:0] val;
        val = 8'd0;
        if (use_imm) begin
            val = imm;
        end else begin
            case (ctype)
                key_extract_pkg::type_6b:   val = cont_6b[idx][7:0];
                key_extract_pkg::type_4b:   val = cont_4b[idx][7:0];
                key_extract_pkg::type_2b:   val = cont_2b[idx][7:0];
                key_extract_pkg::type_none: val = 8'd0;
            endcase
        end
        return val;
    endfunction

    assign opcode = key_extract_pkg::cmp_op_e'(cmp_word[19:18]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op1_q <= 8'd0;
            op2_q <= 8'd0;
        end else begin
            op1_q <= pick_operand(cmp_word[17], cmp_word[16:9],
                                  key_extract_pkg::cont_type_e'(cmp_word[13:12]),
                                  cmp_word[11:9]);
            op2_q <= pick_operand(cmp_word[8], cmp_word[7:0],
                                  key_extract_pkg::cont_type_e'(cmp_word[4:3]),
                                  cmp_word[2:0]);
        end
    end

    // unsigned compare
    always_comb begin
        case (opcode)
            key_extract_pkg::op_gt:   cmp_bit = op1_q > op2_q;
            key_extract_pkg::op_ge:   cmp_bit = op1_q >= op2_q;
            key_extract_pkg::op_eq:   cmp_bit = op1_q == op2_q;
            key_extract_pkg::op_true: cmp_bit = 1'b1;
        endcase
    end

    a_opcode_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(opcode))
        else $error("comparator opcode unknown");

endmodule

// File: source/key_extract_ctrl.sv
// key extractor datapath FSM
// captures the PHV and its containers, builds the key from the tenant's
// offset entry and the predicate bit, masks it and handles the output handshake

`timescale 1ns/1ns

module key_extract_ctrl #(
    parameter int STAGE_ID = 0
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic [key_extract_pkg::phv_len-1:0]       phv_in,
    input  logic                                      phv_valid_in,
    input  logic                                      ready_in,
    output logic                                      ready_out,
    output logic [key_extract_pkg::phv_len-1:0]       phv_out,
    output logic                                      phv_valid_out,
    output logic [key_extract_pkg::key_len-1:0]       key_out_masked,
    output logic [key_extract_pkg::key_len-1:0]       key_mask_out,
    output logic                                      key_valid_out,
    output logic [key_extract_pkg::tenant_w-1:0]      tenant_addr,
    output logic [key_extract_pkg::cmp_word_w-1:0]    cmp_word,
    output logic [key_extract_pkg::num_cont-1:0][key_extract_pkg::cont_6b_w-1:0] cont_6b,
    output logic [key_extract_pkg::num_cont-1:0][key_extract_pkg::cont_4b_w-1:0] cont_4b,
    output logic [key_extract_pkg::num_cont-1:0][key_extract_pkg::cont_2b_w-1:0] cont_2b,
    input  logic [key_extract_pkg::key_off_len-1:0]   key_offset,
    input  logic [key_extract_pkg::key_len-1:0]       key_mask,
    input  logic                                      cmp_bit
);

    localparam int nc   = key_extract_pkg::num_cont;
    localparam int w6   = key_extract_pkg::cont_6b_w;
    localparam int w4   = key_extract_pkg::cont_4b_w;
    localparam int w2   = key_extract_pkg::cont_2b_w;
    localparam int iw   = key_extract_pkg::cont_idx_w;
    localparam int klen = key_extract_pkg::key_len;
    localparam int olen = key_extract_pkg::key_off_len;
    localparam int cmp_msb = key_extract_pkg::cmp_base - STAGE_ID * key_extract_pkg::cmp_word_w;
    localparam int cmp_bit_pos = key_extract_pkg::num_cmp - 1 - STAGE_ID;

    key_extract_pkg::state_e state_q;
    logic                    accept;
    logic                    ready_seen;
    logic [olen-1:0]         key_off_q;
    logic [klen-1:0]         key_mask_q;
    logic [klen-1:0]         key_d;
    logic [klen-1:0]         key_out;

    // ready only while idle since one item is in flight
    assign ready_out = (state_q == key_extract_pkg::idle);
    assign accept    = ready_out && phv_valid_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q       <= key_extract_pkg::idle;
            ready_seen    <= 1'b0;
            phv_valid_out <= 1'b0;
            key_valid_out <= 1'b0;
            phv_out       <= '0;
            key_out       <= '0;
            key_mask_out  <= '0;
            tenant_addr   <= '0;
            cmp_word      <= '0;
        end else begin
            ready_seen    <= ready_in;
            phv_valid_out <= 1'b0;
            key_valid_out <= 1'b0;
            case (state_q)
                key_extract_pkg::idle: begin
                    if (accept) begin
                        phv_out     <= phv_in;
                        tenant_addr <= phv_in[key_extract_pkg::tenant_lsb +: key_extract_pkg::tenant_w];
                        cmp_word    <= phv_in[cmp_msb -: key_extract_pkg::cmp_word_w];
                        state_q     <= key_extract_pkg::wait_operands;
                    end
                end
                // comparator registers operands while tables read the tenant entry
                key_extract_pkg::wait_operands: state_q <= key_extract_pkg::wait_table;
                key_extract_pkg::wait_table:    state_q <= key_extract_pkg::emit;
                key_extract_pkg::emit: begin
                    key_out      <= key_d;
                    key_mask_out <= key_mask_q;
                    state_q      <= key_extract_pkg::halt;
                end
                // release once ready_in was sampled high in emit or halt
                key_extract_pkg::halt: begin
                    if (ready_seen) begin
                        phv_valid_out <= 1'b1;
                        key_valid_out <= 1'b1;
                        state_q       <= key_extract_pkg::idle;
                    end
                end
                default: state_q <= key_extract_pkg::idle;
            endcase
        end
    end

    // container capture and table entry hold
    always_ff @(posedge clk) begin
        if (accept) begin
            cont_6b <= phv_in[key_extract_pkg::cont_6b_msb -: nc * w6];
            cont_4b <= phv_in[key_extract_pkg::cont_4b_msb -: nc * w4];
            cont_2b <= phv_in[key_extract_pkg::cont_2b_msb -: nc * w2];
        end
        // hold the entries read for this item against later writes
        if (state_q == key_extract_pkg::wait_table) begin
            key_off_q  <= key_offset;
            key_mask_q <= key_mask;
        end
    end

    always_comb begin
        key_d = '0;
        key_d[klen-1 -: w6]               = cont_6b[key_off_q[olen-1 -: iw]];
        key_d[klen-1-w6 -: w6]            = cont_6b[key_off_q[olen-1-iw -: iw]];
        key_d[klen-1-2*w6 -: w4]          = cont_4b[key_off_q[olen-1-2*iw -: iw]];
        key_d[klen-1-2*w6-w4 -: w4]       = cont_4b[key_off_q[olen-1-3*iw -: iw]];
        key_d[klen-1-2*w6-2*w4 -: w2]     = cont_2b[key_off_q[olen-1-4*iw -: iw]];
        key_d[klen-1-2*w6-2*w4-w2 -: w2]  = cont_2b[key_off_q[olen-1-5*iw -: iw]];
        // other stages' comparator bits stay zero
        key_d[cmp_bit_pos] = cmp_bit;
    end

    // masked bits are cleared
    assign key_out_masked = key_out & ~key_mask_out;

    // both valids pulse together and only after ready_in was sampled high
    a_valid_pair: assert property (@(posedge clk) disable iff (!rst_n)
        (phv_valid_out == key_valid_out) &&
        (!phv_valid_out || $past(ready_in, 2)))
        else $error("output valids out of step or pulse without ready_in");

endmodule

// File: source/key_extract_top.sv
// key extractor top level
// datapath FSM, stage comparator and the two per-tenant tables
// (key offset and key mask) behind a plain table write port

`timescale 1ns/1ns

module key_extract_top #(
    parameter int STAGE_ID    = 0,
    parameter int TABLE_DEPTH = 16
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [key_extract_pkg::phv_len-1:0]    phv_in,
    input  logic                                   phv_valid_in,
    input  logic                                   ready_in,
    output logic                                   ready_out,
    output logic [key_extract_pkg::phv_len-1:0]    phv_out,
    output logic                                   phv_valid_out,
    output logic [key_extract_pkg::key_len-1:0]    key_out_masked,
    output logic [key_extract_pkg::key_len-1:0]    key_mask_out,
    output logic                                   key_valid_out,
    input  logic                                   table_wr_en,
    input  key_extract_pkg::table_sel_e            table_wr_sel,
    input  logic [key_extract_pkg::tenant_w-1:0]   table_wr_addr,
    input  logic [key_extract_pkg::key_len-1:0]    table_wr_data
);

    logic [key_extract_pkg::tenant_w-1:0]    tenant_addr;
    logic [key_extract_pkg::cmp_word_w-1:0]  cmp_word;
    logic [key_extract_pkg::num_cont-1:0][key_extract_pkg::cont_6b_w-1:0] cont_6b;
    logic [key_extract_pkg::num_cont-1:0][key_extract_pkg::cont_4b_w-1:0] cont_4b;
    logic [key_extract_pkg::num_cont-1:0][key_extract_pkg::cont_2b_w-1:0] cont_2b;
    logic [key_extract_pkg::key_off_len-1:0] key_offset;
    logic [key_extract_pkg::key_len-1:0]     key_mask;
    logic                                    cmp_bit;
    logic                                    off_wr_en;
    logic                                    mask_wr_en;

    // write enable goes to the selected table only
    assign off_wr_en  = table_wr_en && (table_wr_sel == key_extract_pkg::sel_offset);
    assign mask_wr_en = table_wr_en && (table_wr_sel == key_extract_pkg::sel_mask);

    key_extract_ctrl #(
        .STAGE_ID (STAGE_ID)
    ) ctrl0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .phv_in         (phv_in),
        .phv_valid_in   (phv_valid_in),
        .ready_in       (ready_in),
        .ready_out      (ready_out),
        .phv_out        (phv_out),
        .phv_valid_out  (phv_valid_out),
        .key_out_masked (key_out_masked),
        .key_mask_out   (key_mask_out),
        .key_valid_out  (key_valid_out),
        .tenant_addr    (tenant_addr),
        .cmp_word       (cmp_word),
        .cont_6b        (cont_6b),
        .cont_4b        (cont_4b),
        .cont_2b        (cont_2b),
        .key_offset     (key_offset),
        .key_mask       (key_mask),
        .cmp_bit        (cmp_bit)
    );

    key_operand_compare cmp0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmp_word (cmp_word),
        .cont_6b  (cont_6b),
        .cont_4b  (cont_4b),
        .cont_2b  (cont_2b),
        .cmp_bit  (cmp_bit)
    );

    // offset entries use the low data bits
    lookup_ram #(
        .DATA_W      (key_extract_pkg::key_off_len),
        .TABLE_DEPTH (TABLE_DEPTH)
    ) offset_table (
        .clk     (clk),
        .wr_en   (off_wr_en),
        .wr_addr (table_wr_addr),
        .wr_data (table_wr_data[key_extract_pkg::key_off_len-1:0]),
        .rd_addr (tenant_addr),
        .rd_data (key_offset)
    );

    lookup_ram #(
        .DATA_W      (key_extract_pkg::key_len),
        .TABLE_DEPTH (TABLE_DEPTH)
    ) mask_table (
        .clk     (clk),
        .wr_en   (mask_wr_en),
        .wr_addr (table_wr_addr),
        .wr_data (table_wr_data),
        .rd_addr (tenant_addr),
        .rd_data (key_mask)
    );

endmodule

// File: test/tb_key_extract.sv
// key extractor testbench
// random PHVs and table entries from a fixed-seed LCG, checked against a
// reference model of the key, mask, predicate bit and output handshake

`timescale 1ns/1ns

module tb_key_extract;

    localparam int stage_id  = 2;
    localparam int phv_len   = key_extract_pkg::phv_len;
    localparam int key_len   = key_extract_pkg::key_len;
    localparam int off_len   = key_extract_pkg::key_off_len;
    localparam int tenant_w  = key_extract_pkg::tenant_w;
    localparam int cw        = key_extract_pkg::cmp_word_w;
    localparam int nc        = key_extract_pkg::num_cont;
    localparam int w6        = key_extract_pkg::cont_6b_w;
    localparam int w4        = key_extract_pkg::cont_4b_w;
    localparam int w2        = key_extract_pkg::cont_2b_w;
    // containers sit above the comparator words, 2B lowest
    localparam int lsb_2b    = key_extract_pkg::cmp_base + 1;
    localparam int lsb_4b    = lsb_2b + nc * w2;
    localparam int lsb_6b    = lsb_4b + nc * w4;
    localparam int word_msb  = key_extract_pkg::cmp_base - stage_id * cw;
    localparam int pred_pos  = key_extract_pkg::num_cmp - 1 - stage_id;

    localparam int n_key = 40;
    localparam int n_lat = 8;
    localparam int n_cmp = 60;
    localparam int n_bp  = 30;
    localparam int n_rw  = 12;
    localparam int max_stall   = 6;
    localparam int cycle_limit = (n_key + n_lat + n_cmp + n_bp + n_rw) * (8 + max_stall) + 200;

    logic                         clk;
    logic                         rst_n;
    logic [phv_len-1:0]           phv_in;
    logic                         phv_valid_in;
    logic                         ready_in;
    logic                         ready_out;
    logic [phv_len-1:0]           phv_out;
    logic                         phv_valid_out;
    logic [key_len-1:0]           key_out_masked;
    logic [key_len-1:0]           key_mask_out;
    logic                         key_valid_out;
    logic                         table_wr_en;
    key_extract_pkg::table_sel_e  table_wr_sel;
    logic [tenant_w-1:0]          table_wr_addr;
    logic [key_len-1:0]           table_wr_data;

    logic [31:0]        rng_state = 32'h0033_1bc1;
    logic [off_len-1:0] off_model [16];
    logic [key_len-1:0] mask_model [16];
    int                 checks = 0;
    int                 errors = 0;
    int                 errors_at_start = 0;
    int                 test_count = 0;
    int                 cycle_count;

    key_extract_top #(
        .STAGE_ID    (stage_id),
        .TABLE_DEPTH (16)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .phv_in         (phv_in),
        .phv_valid_in   (phv_valid_in),
        .ready_in       (ready_in),
        .ready_out      (ready_out),
        .phv_out        (phv_out),
        .phv_valid_out  (phv_valid_out),
        .key_out_masked (key_out_masked),
        .key_mask_out   (key_mask_out),
        .key_valid_out  (key_valid_out),
        .table_wr_en    (table_wr_en),
        .table_wr_sel   (table_wr_sel),
        .table_wr_addr  (table_wr_addr),
        .table_wr_data  (table_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_random();
        return int'(r >> 8) % n;
    endfunction

    function automatic logic [phv_len-1:0] random_phv();
        logic [phv_len-1:0] v;
        v = '0;
        for (int i = 0; i < (phv_len + 31) / 32; i++) begin
            v = {v[phv_len-33:0], next_random()};
        end
        return v;
    endfunction

    function automatic logic [key_len-1:0] random_key();
        logic [key_len-1:0] v;
        v = '0;
        for (int i = 0; i < (key_len + 31) / 32; i++) begin
            v = {v[key_len-33:0], next_random()};
        end
        return v;
    endfunction

    function automatic logic [tenant_w-1:0] random_tenant();
        logic [31:0] r;
        r = next_random();
        return r[27:24];
    endfunction

    function automatic logic [phv_len-1:0] phv_for_tenant(input logic [tenant_w-1:0] tenant);
        logic [phv_len-1:0] v;
        v = random_phv();
        v[key_extract_pkg::tenant_lsb +: tenant_w] = tenant;
        return v;
    endfunction

    // operand container type codes: 10 is 6B, 01 is 4B, 00 is 2B, 11 is none
    function automatic logic [1:0] type_code(input int src);
        case (src)
            1:       return 2'b10;
            2:       return 2'b01;
            3:       return 2'b00;
            default: return 2'b11;
        endcase
    endfunction

    function automatic logic [7:0] model_operand(input logic [phv_len-1:0] phv,
                                                 input logic use_imm,
                                                 input logic [7:0] field);
        logic [nc-1:0][w6-1:0] c6;
        logic [nc-1:0][w4-1:0] c4;
        logic [nc-1:0][w2-1:0] c2;
        logic [7:0]            v;
        c6 = phv[lsb_6b +: nc * w6];
        c4 = phv[lsb_4b +: nc * w4];
        c2 = phv[lsb_2b +: nc * w2];
        v = field;
        if (!use_imm) begin
            case (field[4:3])
                2'b10:   v = c6[field[2:0]][7:0];
                2'b01:   v = c4[field[2:0]][7:0];
                2'b00:   v = c2[field[2:0]][7:0];
                default: v = 8'd0;
            endcase
        end
        return v;
    endfunction

    function automatic logic model_predicate(input logic [phv_len-1:0] phv);
        logic [cw-1:0] word;
        logic [7:0]    a;
        logic [7:0]    b;
        word = phv[word_msb -: cw];
        a = model_operand(phv, word[17], word[16:9]);
        b = model_operand(phv, word[8], word[7:0]);
        case (word[19:18])
            2'b00:   return a > b;
            2'b01:   return a >= b;
            2'b10:   return a == b;
            default: return 1'b1;
        endcase
    endfunction

    // 6B pair, 4B pair, 2B pair, then one bit per stage
    function automatic logic [key_len-1:0] model_key(input logic [phv_len-1:0] phv,
                                                     input logic [off_len-1:0] off);
        logic [nc-1:0][w6-1:0]                  c6;
        logic [nc-1:0][w4-1:0]                  c4;
        logic [nc-1:0][w2-1:0]                  c2;
        logic [key_extract_pkg::num_cmp-1:0]    cmp_bits;
        c6 = phv[lsb_6b +: nc * w6];
        c4 = phv[lsb_4b +: nc * w4];
        c2 = phv[lsb_2b +: nc * w2];
        cmp_bits = '0;
        cmp_bits[pred_pos] = model_predicate(phv);
        return {c6[off[17:15]], c6[off[14:12]], c4[off[11:9]], c4[off[8:6]],
                c2[off[5:3]], c2[off[2:0]], cmp_bits};
    endfunction

    task automatic check_key(input string name, input logic [key_len-1:0] exp,
                             input logic [key_len-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_phv(input string name, input logic [phv_len-1:0] exp,
                             input logic [phv_len-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic write_entry(input key_extract_pkg::table_sel_e sel,
                               input logic [tenant_w-1:0] addr,
                               input logic [key_len-1:0] data);
        table_wr_en   = 1'b1;
        table_wr_sel  = sel;
        table_wr_addr = addr;
        table_wr_data = data;
        @(posedge clk);
        #1;
        table_wr_en = 1'b0;
        if (sel == key_extract_pkg::sel_offset) begin
            off_model[addr] = data[off_len-1:0];
        end else begin
            mask_model[addr] = data;
        end
    endtask

    // one PHV through the block, ready_in low for stall edges from emit on
    task automatic run_packet(input string name, input logic [phv_len-1:0] phv,
                              input int stall);
        logic [tenant_w-1:0] tenant;
        logic [key_len-1:0]  exp_key;
        logic [key_len-1:0]  exp_mask;
        int                  edges;
        logic                seen;
        tenant   = phv[key_extract_pkg::tenant_lsb +: tenant_w];
        exp_key  = model_key(phv, off_model[tenant]);
        exp_mask = mask_model[tenant];
        check_bit({name, " ready_out idle"}, 1'b1, ready_out);
        phv_in       = phv;
        phv_valid_in = 1'b1;
        ready_in     = 1'b1;
        @(posedge clk);
        #1;
        phv_valid_in = 1'b0;
        phv_in       = random_phv();
        edges = 0;
        seen  = 1'b0;
        while (!seen) begin
            // high before emit must not count
            ready_in = (edges + 1 < 3) || (edges + 1 >= 3 + stall);
            @(posedge clk);
            #1;
            edges++;
            if (phv_valid_out || key_valid_out) begin
                seen = 1'b1;
            end else begin
                check_bit({name, " ready_out busy"}, 1'b0, ready_out);
            end
        end
        check_count({name, " latency"}, 4 + stall, edges);
        check_bit({name, " phv_valid_out"}, 1'b1, phv_valid_out);
        check_bit({name, " key_valid_out"}, 1'b1, key_valid_out);
        check_key({name, " key_out_masked"}, exp_key & ~exp_mask, key_out_masked);
        check_key({name, " key_mask_out"}, exp_mask, key_mask_out);
        check_phv({name, " phv_out"}, phv, phv_out);
        check_bit({name, " ready_out after"}, 1'b1, ready_out);
        if (!exp_mask[pred_pos]) begin
            check_bit({name, " predicate"}, model_predicate(phv), key_out_masked[pred_pos]);
        end
        ready_in = 1'b1;
        @(posedge clk);
        #1;
        check_bit({name, " single pulse"}, 1'b0, phv_valid_out || key_valid_out);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [phv_len-1:0]  phv;
        logic [tenant_w-1:0] rw_tenant;
        logic [tenant_w-1:0] tenant;
        logic [31:0]         r;
        logic [7:0]          fsrc;
        logic [7:0]          fimm;
        logic                flag_src;
        logic [cw-1:0]       word;
        rst_n         = 1'b0;
        phv_in        = '0;
        phv_valid_in  = 1'b0;
        ready_in      = 1'b0;
        table_wr_en   = 1'b0;
        table_wr_sel  = key_extract_pkg::sel_offset;
        table_wr_addr = '0;
        table_wr_data = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_bit("reset ready_out", 1'b1, ready_out);
        check_bit("reset phv_valid_out", 1'b0, phv_valid_out);
        check_bit("reset key_valid_out", 1'b0, key_valid_out);
        check_key("reset key_out_masked", '0, key_out_masked);
        check_key("reset key_mask_out", '0, key_mask_out);
        check_phv("reset phv_out", '0, phv_out);
        finish_test("reset");

        for (int t = 0; t < 16; t++) begin
            write_entry(key_extract_pkg::sel_offset, t[3:0], random_key());
            write_entry(key_extract_pkg::sel_mask, t[3:0], random_key());
        end
        for (int i = 0; i < n_key; i++) begin
            run_packet($sformatf("key %0d", i), phv_for_tenant(random_tenant()), 0);
        end
        finish_test("key assembly");

        for (int i = 0; i < n_lat; i++) begin
            run_packet($sformatf("latency %0d", i), phv_for_tenant(random_tenant()), 0);
        end
        finish_test("latency");

        // comparator bits unmasked so the predicate shows on the output
        for (int t = 0; t < 16; t++) begin
            write_entry(key_extract_pkg::sel_mask, t[3:0],
                        random_key() & ~{{(key_len - 5){1'b0}}, 5'h1f});
        end
        for (int op = 0; op < 4; op++) begin
            for (int src = 0; src < 5; src++) begin
                for (int side = 0; side < 2; side++) begin
                    r        = next_random();
                    flag_src = (src == 0);
                    if (src == 0) begin
                        fsrc = r[23:16];
                    end else begin
                        fsrc = {r[23:21], type_code(src), r[18:16]};
                    end
                    phv  = phv_for_tenant(random_tenant());
                    fimm = r[31:24];
                    // equal opcode gets a matching immediate
                    if (op == 2) begin
                        fimm = model_operand(phv, flag_src, fsrc);
                    end
                    if (side == 0) begin
                        word = {op[1:0], flag_src, fsrc, 1'b1, fimm};
                    end else begin
                        word = {op[1:0], 1'b1, fimm, flag_src, fsrc};
                    end
                    phv[word_msb -: cw] = word;
                    run_packet($sformatf("cmp op%0d src%0d side%0d", op, src, side), phv, 0);
                end
            end
        end
        for (int i = 0; i < n_cmp - 40; i++) begin
            run_packet($sformatf("cmp random %0d", i), phv_for_tenant(random_tenant()), 0);
        end
        finish_test("comparator");

        for (int i = 0; i < n_bp; i++) begin
            run_packet($sformatf("stall %0d", i), phv_for_tenant(random_tenant()),
                       rand_below(max_stall + 1));
        end
        finish_test("back-pressure");

        rw_tenant = random_tenant();
        for (int i = 0; i < n_rw; i++) begin
            if (i == n_rw / 2) begin
                write_entry(key_extract_pkg::sel_offset, rw_tenant, random_key());
                write_entry(key_extract_pkg::sel_mask, rw_tenant, random_key());
            end
            if (i % 2 == 0) begin
                tenant = rw_tenant;
            end else begin
                tenant = rw_tenant + 4'(1 + rand_below(15));
            end
            run_packet($sformatf("rewrite %0d", i), phv_for_tenant(tenant), rand_below(2));
        end
        finish_test("table rewrite");

        $display("%0d tests, %0d checks, %0d errors", test_count, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
source/key_extract_pkg.sv
source/lookup_ram.sv
source/key_operand_compare.sv
source/key_extract_ctrl.sv
source/key_extract_top.sv
test/tb_key_extract.sv

// File: Makefile
TOOL     = verilator
TOP      = tb_key_extract
FILELIST = filelist.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ns --top-module $(TOP)
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
